//--- cpu_core.f
source/cpu_pkg.sv
source/cpu_sequencer.sv
source/cpu_address_unit.sv
source/cpu_registers.sv
source/cpu_alu.sv
source/cpu_core.sv
dv/cpu_core_chk.sv
dv/cpu_core_tb.sv

//--- dv/cpu_core_chk.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core_chk (
    input logic        clock,
    input logic        reset,
    input logic        enable,
    input logic [15:0] address,
    input logic [7:0]  data_in,
    input logic        write_enable,
    input logic        sync
);

    int         failures = 0;  // read by the testbench summary
    logic [7:0] opcode_seen;   // last opcode taken off the bus
    logic [1:0] cycle_count;   // enabled cycles since that fetch, stops at 3
    logic       store_op;

    assign store_op = opcode_seen inside {8'h84, 8'h85, 8'h86};  // sty sta stx $zp

    always_ff @(posedge clock) begin
        if (reset)
            cycle_count <= 2'd3;  // reset starts mid-jmp, no opcode seen yet
        else if (enable) begin
            if (sync) begin
                opcode_seen <= data_in;
                cycle_count <= 2'd1;  // operand cycle next
            end else if (cycle_count != 2'd3)
                cycle_count <= cycle_count + 2'd1;
        end
    end

    // a store writes in the cycle after its operand fetch and nowhere else
    assert property (@(posedge clock) disable iff (reset)
        write_enable |-> cycle_count == 2'd2 && store_op)
    else begin
        failures++;
        $error("write_enable outside the data cycle of a zero page store");
    end

    assert property (@(posedge clock) disable iff (reset) sync && enable |=> !sync)
    else begin
        failures++;
        $error("sync high in two enabled cycles in a row");
    end

    // stall holds the bus
    assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(address) && $stable(write_enable) && $stable(sync))
    else begin
        failures++;
        $error("bus outputs changed while enable was low");
    end

endmodule

bind cpu_core cpu_core_chk chk_i (.*);

`default_nettype wire

//--- dv/cpu_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

    logic        clock, reset, enable, write_enable, sync;
    logic [7:0]  data_in, data_out, debug_a, debug_x, debug_y;
    logic [15:0] address, debug_pc;
    logic [3:0]  debug_flags;

    logic [7:0]  mem [0:65535];     // whole address space, program at 0200
    logic [7:0]  model_zp [0:255];  // zero page as the model sees it
    logic [7:0]  prog [$];
    logic [15:0] m_pc, store_addr;
    logic [7:0]  m_a, m_x, m_y;
    logic        m_n, m_v, m_z, m_c, store_pending, halted, done;
    integer      seed, errors, checks, tests_done, prog_len, timeout_ns;
    string       test_names [5] = '{"reset vector", "loads and transfers", "alu operations",
                                    "stores", "jmp absolute"};

    cpu_core dut_i (.*);

    assign data_in = mem[address];  // combinational read

    initial clock = 1'b0;
    always #5 clock = ~clock;

    always @(posedge clock) begin
        #1 enable <= ($random(seed) & 3) != 0;  // stalls about one cycle in four
    end

    always @(posedge clock) begin
        if (!reset && enable && write_enable)
            mem[address] <= data_out;
    end

    function automatic logic [7:0] rnd();
        return 8'($random(seed));
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, what);
        end
    endtask

    task automatic set_nz(input logic [7:0] value);
        m_n = value[7];
        m_z = value == 8'h00;
    endtask

    task automatic store_model(input logic [7:0] zp, input logic [7:0] value);
        model_zp[zp]  = value;
        store_addr    = {8'h00, zp};
        store_pending = 1'b1;
    endtask

    // 6502 rules for the eight group-one operations
    task automatic alu_model(input logic [2:0] aop, input logic [7:0] m);
        logic [8:0] wide;
        case (aop)
            3'd0: m_a = m_a | m;
            3'd1: m_a = m_a & m;
            3'd2: m_a = m_a ^ m;
            3'd3: begin
                wide = {1'b0, m_a} + {1'b0, m} + {8'd0, m_c};
                m_v  = (m_a[7] == m[7]) && (wide[7] != m_a[7]);  // same signs, result flips
                m_c  = wide[8];
                m_a  = wide[7:0];
            end
            3'd6: begin
                m_c = m_a >= m;  // no borrow
                set_nz(m_a - m);
            end
            3'd7: begin
                wide = {1'b0, m_a} - {1'b0, m} - {8'd0, ~m_c};
                m_v  = (m_a[7] != m[7]) && (wide[7] != m_a[7]);
                m_c  = ~wide[8];
                m_a  = wide[7:0];
            end
            default: m_a = m;  // lda
        endcase
        if (aop != 3'd6)
            set_nz(m_a);
    endtask

    task automatic step_model();
        logic [7:0]  op, opr, m;
        logic [15:0] target;
        op     = mem[m_pc];
        opr    = mem[m_pc + 16'd1];
        m      = model_zp[opr];
        target = {mem[m_pc + 16'd2], opr};
        m_pc   = m_pc + 16'd1;
        if (op[4:0] == 5'b01001 && op != 8'h89) begin  // group one #imm
            m_pc++;
            alu_model(op[7:5], opr);
        end else if (op[4:0] == 5'b00101) begin  // group one $zp
            m_pc++;
            if (op[7:5] == 3'd4)
                store_model(opr, m_a);
            else
                alu_model(op[7:5], m);
        end else begin
            case (op)
                opcode_jmp_abs: begin
                    halted = target == m_pc - 16'd1;  // jump to itself ends the program
                    m_pc   = target;
                end
                8'ha2: begin m_pc++; m_x = opr; set_nz(opr); end
                8'ha0: begin m_pc++; m_y = opr; set_nz(opr); end
                8'ha6: begin m_pc++; m_x = m; set_nz(m); end
                8'ha4: begin m_pc++; m_y = m; set_nz(m); end
                8'h86: begin m_pc++; store_model(opr, m_x); end
                8'h84: begin m_pc++; store_model(opr, m_y); end
                8'haa: begin m_x = m_a; set_nz(m_x); end
                8'ha8: begin m_y = m_a; set_nz(m_y); end
                8'h8a: begin m_a = m_x; set_nz(m_a); end
                8'h98: begin m_a = m_y; set_nz(m_a); end
                8'he8: begin m_x = m_x + 8'd1; set_nz(m_x); end
                8'hc8: begin m_y = m_y + 8'd1; set_nz(m_y); end
                8'hca: begin m_x = m_x - 8'd1; set_nz(m_x); end
                8'h88: begin m_y = m_y - 8'd1; set_nz(m_y); end
                8'h18: m_c = 1'b0;
                8'h38: m_c = 1'b1;
                8'hea: begin  // nop marks the end of a test
                    $display("test %0d %s finished, %0d errors so far", tests_done + 1,
                             test_names[tests_done], errors);
                    tests_done++;
                end
                default: ;  // unknown opcode, one byte nop
            endcase
        end
    endtask

    task automatic compare_state();
        check(debug_pc == m_pc, $sformatf("pc %h, expected %h", debug_pc, m_pc));
        check(debug_a == m_a, $sformatf("a %h, expected %h at pc %h", debug_a, m_a, m_pc));
        check(debug_x == m_x, $sformatf("x %h, expected %h at pc %h", debug_x, m_x, m_pc));
        check(debug_y == m_y, $sformatf("y %h, expected %h at pc %h", debug_y, m_y, m_pc));
        check(debug_flags == {m_n, m_v, m_z, m_c},
              $sformatf("nvzc %b, expected %b at pc %h", debug_flags, {m_n, m_v, m_z, m_c}, m_pc));
        if (store_pending)
            check(mem[store_addr] == model_zp[store_addr[7:0]],
                  $sformatf("zp %h holds %h, expected %h", store_addr[7:0], mem[store_addr],
                            model_zp[store_addr[7:0]]));
        store_pending = 1'b0;
    endtask

    // each opcode fetch closes the previous instruction
    always @(posedge clock) begin
        if (!reset && enable && sync && !done) begin
            compare_state();
            if (halted)
                done = 1'b1;
            else
                step_model();
        end
    end

    // first two enabled reads fetch the vector
    initial begin
        @(negedge reset);
        for (int i = 0; i < 2; i++) begin
            do @(posedge clock); while (!enable);
            check(address == 16'hfffc + 16'(i),
                  $sformatf("vector read at %h, expected %h", address, 16'hfffc + 16'(i)));
        end
    end

    initial begin
        #1;
        timeout_ns = 40 * (3 * (prog_len + 4) + 18);  // 4x the worst case at 10 ns a cycle
        #(timeout_ns);
        $display("watchdog: the program did not reach its halt loop within %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [7:0] r;
        logic [2:0] aop;
        seed          = 32'ha546;
        errors        = 0;
        checks        = 0;
        tests_done    = 0;
        reset         = 1'b1;
        enable        = 1'b0;
        {m_a, m_x, m_y} = 24'h0;
        {m_n, m_v, m_z, m_c} = 4'h0;
        store_pending = 1'b0;
        halted        = 1'b0;
        done          = 1'b0;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i[15:8] ^ i[7:0] ^ 8'h3c);
        for (int i = 0; i < 256; i++)
            model_zp[i] = mem[i];
        prog = {8'hea,  // test 1 ends right after the vector jump
                8'ha9, rnd(), 8'haa, 8'ha8, 8'he8, 8'hc8, 8'hca, 8'h88, 8'ha2, 8'h00, 8'hca,
                8'ha0, rnd(), 8'h8a, 8'h98, 8'ha5, 8'h80, 8'ha6, 8'h31, 8'ha4, 8'hc3,
                8'h02, 8'hea};
        for (int i = 0; i < 24; i++) begin
            r   = rnd();
            aop = (i[2:0] == 3'd4) ? 3'd3 : i[2:0];  // no sta here, extra adc instead
            prog.push_back(r[3] ? 8'h38 : 8'h18);    // sec or clc
            prog.push_back({aop, i[3] ? 3'b001 : 3'b010, 2'b01});  // zp for the middle eight
            prog.push_back(rnd());
        end
        prog = {prog, 8'hea, 8'ha9, rnd(), 8'h85, 8'h10, 8'ha2, rnd(), 8'h86, 8'h11,
                8'ha0, rnd(), 8'h84, 8'h12, 8'ha5, 8'h12, 8'ha6, 8'h10, 8'ha4, 8'h11,
                8'hea, 8'h4c, 8'h00, 8'h04};
        foreach (prog[i])
            mem[16'h0200 + 16'(i)] = prog[i];
        prog_len = prog.size();
        mem[16'h0400] = 8'hea;  // jmp lands here, then loops on itself
        mem[16'h0401] = 8'h4c;
        mem[16'h0402] = 8'h01;
        mem[16'h0403] = 8'h04;
        mem[16'hfffc] = 8'h00;
        mem[16'hfffd] = 8'h02;
        m_pc = {mem[16'hfffd], mem[16'hfffc]};
        repeat (16) @(posedge clock);
        #1 reset = 1'b0;
        wait (done);
        errors = errors + dut_i.chk_i.failures;
        $display("%0d tests finished, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_core_tb -f cpu_core.f

# a failed assertion must not stop the run before the testbench prints its summary
./obj_dir/Vcpu_core_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi

//--- source/cpu_address_unit.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_address_unit import cpu_pkg::*; #(
    parameter logic [15:0] reset_vector = reset_vector_default
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable,
    input  logic        pc_increment,
    input  logic        pc_load_vector,
    input  logic        vector_low_capture,
    input  logic        zero_page_access,
    input  logic [7:0]  data_in,
    output logic [15:0] address,
    output logic [15:0] pc
);

    logic [7:0] low_byte;  // operand byte from the previous cycle

    // zero page ops put the latched operand on the bus, everything else reads at pc
    assign address = zero_page_access ? {8'h00, low_byte} : pc;

    always_ff @(posedge clock) begin
        if (reset)
            pc <= reset_vector;
        else if (enable) begin
            if (pc_load_vector)
                pc <= {data_in, low_byte};  // high byte arrives this cycle
            else if (pc_increment)
                pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (enable && vector_low_capture)
            low_byte <= data_in;
    end

endmodule

`default_nettype wire

//--- source/cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       enable,
    input  logic       flags_from_alu,
    input  logic       flags_nz_only,
    input  logic       carry_write,
    input  logic       set_carry_value,
    input  alu_op_e    alu_op,
    input  logic [7:0] a_value,
    input  logic [7:0] data_in,
    input  logic [7:0] db,
    output logic [7:0] alu_result,
    output logic [3:0] flags
);

    logic       flag_n, flag_v, flag_z, flag_c;
    logic       subtract, carry_in, arith, adc_sbc, overflow;
    logic [7:0] operand;
    logic [8:0] sum;

    assign subtract = alu_op == op_cmp || alu_op == op_sbc;
    assign operand  = subtract ? ~data_in : data_in;          // a - m = a + ~m + c
    assign carry_in = (alu_op == op_cmp) ? 1'b1 : flag_c;     // compare ignores c
    assign sum      = {1'b0, a_value} + {1'b0, operand} + {8'd0, carry_in};
    assign adc_sbc  = alu_op == op_adc || alu_op == op_sbc;
    assign arith    = adc_sbc || alu_op == op_cmp;
    assign overflow = (a_value[7] ^ sum[7]) & (operand[7] ^ sum[7]);  // sign flip

    always_comb begin
        case (alu_op)
            op_ora: alu_result = a_value | data_in;
            op_and: alu_result = a_value & data_in;
            op_eor: alu_result = a_value ^ data_in;
            op_adc: alu_result = sum[7:0];
            op_sta: alu_result = a_value;   // store data comes off the bus instead
            op_lda: alu_result = data_in;
            op_cmp: alu_result = sum[7:0];  // difference, only for n and z
            op_sbc: alu_result = sum[7:0];
        endcase
    end

    // n and z always follow the bus value of the cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else if (enable) begin
            if (flags_from_alu || flags_nz_only) begin
                flag_n <= db[7];
                flag_z <= db == 8'h00;
            end
            if (flags_from_alu && arith)
                flag_c <= sum[8];
            else if (carry_write)
                flag_c <= set_carry_value;  // clc / sec
            if (flags_from_alu && adc_sbc)
                flag_v <= overflow;
        end
    end

    assign flags = {flag_n, flag_v, flag_z, flag_c};

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
    parameter logic [15:0] reset_vector = reset_vector_default
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        enable,        // low stalls the whole core
    input  logic [7:0]  data_in,
    output logic [15:0] address,
    output logic [7:0]  data_out,
    output logic        write_enable,
    output logic        sync,
    output logic [15:0] debug_pc,
    output logic [7:0]  debug_a,
    output logic [7:0]  debug_x,
    output logic [7:0]  debug_y,
    output logic [3:0]  debug_flags    // n v z c
);

    logic       pc_increment, pc_load_vector, vector_low_capture, zero_page_access;
    logic       a_load, x_load, y_load;
    logic       flags_from_alu, flags_nz_only, carry_write, set_carry_value;
    db_source_e db_source;
    alu_op_e    alu_op;
    logic [7:0] db, alu_result;

    cpu_sequencer sequencer_i (.*);

    cpu_address_unit #(
        .reset_vector(reset_vector)
    ) address_unit_i (
        .clock, .reset, .enable,
        .pc_increment, .pc_load_vector, .vector_low_capture, .zero_page_access,
        .data_in, .address,
        .pc(debug_pc)
    );

    cpu_registers registers_i (
        .clock, .reset, .enable, .a_load, .x_load, .y_load, .db_source,
        .data_in, .alu_result, .db,
        .a_value(debug_a),
        .x_value(debug_x),
        .y_value(debug_y)
    );

    cpu_alu alu_i (
        .clock, .reset, .enable,
        .flags_from_alu, .flags_nz_only, .carry_write, .set_carry_value, .alu_op,
        .a_value(debug_a),
        .data_in, .db, .alu_result,
        .flags(debug_flags)
    );

    assign data_out = db;  // stores drive the selected register on the bus

endmodule

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // instruction cycle of the sequencer
    typedef enum logic [1:0] {
        fetch_opcode,   // opcode byte on the bus, sync high
        fetch_operand,  // byte after the opcode, or the dead cycle of an implied op
        fetch_high,     // high byte of a jmp target
        zero_page       // data access at page zero
    } cpu_state_e;

    // alu operation, straight from opcode bits 7 to 5 of the cc=01 group
    typedef enum logic [2:0] {
        op_ora,
        op_and,
        op_eor,
        op_adc,
        op_sta,
        op_lda,
        op_cmp,
        op_sbc
    } alu_op_e;

    // what drives the internal data bus
    typedef enum logic [3:0] {
        src_memory,
        src_alu,
        src_a,
        src_x,
        src_y,
        src_inc_x,
        src_inc_y,
        src_dec_x,
        src_dec_y
    } db_source_e;

    localparam logic [7:0]  opcode_jmp_abs       = 8'h4c;
    localparam logic [15:0] reset_vector_default = 16'hfffc;  // low byte of the start address

endpackage

`default_nettype wire

//--- source/cpu_registers.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_registers import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       enable,
    input  logic       a_load,
    input  logic       x_load,
    input  logic       y_load,
    input  db_source_e db_source,
    input  logic [7:0] data_in,
    input  logic [7:0] alu_result,
    output logic [7:0] db,
    output logic [7:0] a_value,
    output logic [7:0] x_value,
    output logic [7:0] y_value
);

    // internal data bus, also the store data
    always_comb begin
        case (db_source)
            src_memory: db = data_in;
            src_alu:    db = alu_result;
            src_a:      db = a_value;
            src_x:      db = x_value;
            src_y:      db = y_value;
            src_inc_x:  db = x_value + 8'd1;  // inx
            src_inc_y:  db = y_value + 8'd1;  // iny
            src_dec_x:  db = x_value - 8'd1;  // dex
            src_dec_y:  db = y_value - 8'd1;  // dey
            default:    db = data_in;
        endcase
    end

    // all three registers load from the bus only
    always_ff @(posedge clock) begin
        if (reset) begin
            a_value <= 8'h00;
            x_value <= 8'h00;
            y_value <= 8'h00;
        end else if (enable) begin
            if (a_load)
                a_value <= db;
            if (x_load)
                x_value <= db;
            if (y_load)
                y_value <= db;
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    output logic       pc_increment,
    output logic       pc_load_vector,
    output logic       vector_low_capture,
    output logic       zero_page_access,
    output db_source_e db_source,
    output logic       a_load,
    output logic       x_load,
    output logic       y_load,
    output alu_op_e    alu_op,
    output logic       flags_from_alu,
    output logic       flags_nz_only,
    output logic       carry_write,
    output logic       set_carry_value,
    output logic       write_enable,
    output logic       sync
);

    cpu_state_e state, next_state;
    logic [7:0] opcode;

    // bit field decode of the kept opcodes
    logic is_jmp, is_alu_imm, is_alu_zp, is_xy_imm, is_xy_zp, is_zero_page, is_store;
    db_source_e store_source;

    assign is_jmp       = opcode == opcode_jmp_abs;
    assign is_alu_imm   = opcode ==? 8'b???_010_01;  // ora..sbc #imm, 89 is a 2-byte nop
    assign is_alu_zp    = opcode ==? 8'b???_001_01;  // ora..sbc $zp, includes sta
    assign is_xy_imm    = opcode ==? 8'b101_000_?0;  // ldy / ldx #imm
    assign is_xy_zp     = opcode ==? 8'b10?_001_?0;  // sty stx ldy ldx $zp
    assign is_zero_page = is_alu_zp | is_xy_zp;
    assign is_store     = opcode[7:5] == 3'b100;     // only meaningful with is_zero_page

    assign alu_op = alu_op_e'(opcode[7:5]);
    assign sync   = state == fetch_opcode;

    // bits 1:0 pick the stored register
    always_comb begin
        case (opcode[1:0])
            2'b00:   store_source = src_y;
            2'b10:   store_source = src_x;
            default: store_source = src_a;
        endcase
    end

    always_comb begin
        next_state         = state;
        pc_increment       = 1'b0;
        pc_load_vector     = 1'b0;
        vector_low_capture = 1'b0;
        zero_page_access   = 1'b0;
        db_source          = src_memory;
        a_load             = 1'b0;
        x_load             = 1'b0;
        y_load             = 1'b0;
        flags_from_alu     = 1'b0;
        flags_nz_only      = 1'b0;
        carry_write        = 1'b0;
        set_carry_value    = opcode[5];  // sec has bit 5 set, clc clear
        write_enable       = 1'b0;
        case (state)
            fetch_opcode: begin
                pc_increment = 1'b1;
                next_state   = fetch_operand;
            end
            fetch_operand: begin
                next_state = fetch_opcode;
                if (is_jmp || is_zero_page) begin
                    pc_increment       = 1'b1;
                    vector_low_capture = 1'b1;  // jmp low byte or zp address
                    next_state         = is_jmp ? fetch_high : zero_page;
                end else if (is_alu_imm) begin
                    pc_increment   = 1'b1;
                    db_source      = src_alu;
                    a_load         = alu_op != op_cmp && alu_op != op_sta;
                    flags_from_alu = alu_op != op_sta;
                end else if (is_xy_imm) begin
                    pc_increment  = 1'b1;
                    x_load        = opcode[1];
                    y_load        = ~opcode[1];
                    flags_nz_only = 1'b1;
                end else begin
                    // one byte ops, unknown opcodes fall through as nop
                    case (opcode)
                        8'haa:   begin db_source = src_a;     x_load = 1'b1; end  // tax
                        8'ha8:   begin db_source = src_a;     y_load = 1'b1; end  // tay
                        8'h8a:   begin db_source = src_x;     a_load = 1'b1; end  // txa
                        8'h98:   begin db_source = src_y;     a_load = 1'b1; end  // tya
                        8'he8:   begin db_source = src_inc_x; x_load = 1'b1; end  // inx
                        8'hc8:   begin db_source = src_inc_y; y_load = 1'b1; end  // iny
                        8'hca:   begin db_source = src_dec_x; x_load = 1'b1; end  // dex
                        8'h88:   begin db_source = src_dec_y; y_load = 1'b1; end  // dey
                        8'h18,
                        8'h38:   carry_write = 1'b1;                             // clc / sec
                        default: db_source = src_memory;
                    endcase
                    flags_nz_only = a_load | x_load | y_load;
                end
            end
            fetch_high: begin
                pc_load_vector = 1'b1;  // pc <= {data_in, latched low}
                next_state     = fetch_opcode;
            end
            default: begin  // zero_page
                zero_page_access = 1'b1;
                next_state       = fetch_opcode;
                if (is_store) begin
                    write_enable = 1'b1;
                    db_source    = store_source;
                end else if (is_alu_zp) begin
                    db_source      = src_alu;
                    a_load         = alu_op != op_cmp;
                    flags_from_alu = 1'b1;
                end else begin
                    x_load        = opcode[1];  // ldx, else ldy
                    y_load        = ~opcode[1];
                    flags_nz_only = 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state  <= fetch_operand;   // start mid-jmp so the vector gets fetched
            opcode <= opcode_jmp_abs;
        end else if (enable) begin
            state <= next_state;
            if (state == fetch_opcode)
                opcode <= data_in;
        end
    end

endmodule

`default_nettype wire
